/* include/gac_defines.svh */
// group action classifier constants

`ifndef GAC_DEFINES_SVH
`define GAC_DEFINES_SVH

// ********************
// module ids
// ********************

`define GAC_LOCAL_MID 8'd4 // packets for this stage
`define GAC_NEXT_MID 8'd5 // stage after the classifier

// ********************
// ingress buffering
// ********************

`define GAC_DATA_DEPTH 512 // packet words
`define GAC_MD_DEPTH 32 // metadata words

// free entries still left when almost-full rises
`define GAC_ALF_MARGIN 8

`endif

/* src/gac_pkg.sv */
// group action classifier types

`default_nettype none

package gac_pkg;

	typedef logic [133:0] pkt_word_t;
	typedef logic [1:0] marker_t;
	typedef logic [7:0] mid_t;
	typedef logic [5:0] port_t;
	typedef logic [7:0] tbl_addr_t;
	typedef logic [31:0] action_t; // code 31:28, id 7:0, port 5:0

	localparam marker_t MARK_TAIL = 2'b10;

	// metadata word, msb first
	typedef struct packed {
		logic pkt_src;
		logic pkt_des;
		port_t in_port;
		logic [1:0] out_type;
		port_t out_port;
		logic [2:0] prio; // forwarding priority
		logic discard;
		logic [19:0] rsv_hi;
		mid_t dmid;
		logic [21:0] rsv_mid;
		tbl_addr_t index;
		logic [49:0] rsv_lo;
	} md_t;

	// other codes forward with the next id
	typedef enum logic [3:0] {
		ACT_CPU_FIXED = 4'd1,
		ACT_CPU_POLL = 4'd2,
		ACT_PORT = 4'd3,
		ACT_SET_MID = 4'd4
	} act_code_e;

	typedef struct packed {
		md_t md;
		action_t action;
		logic hit;
	} dec_item_t;

	typedef struct packed {
		md_t md;
		logic keep_first; // foreign id, first word untouched
	} hdr_item_t;

	typedef enum logic [2:0] {
		DEC_IDLE,
		DEC_LOOKUP,
		DEC_WAIT,
		DEC_ISSUE,
		DEC_BUSY
	} dec_state_e;

	typedef enum logic [2:0] {
		CFG_IDLE,
		CFG_WRITE,
		CFG_READ,
		CFG_WAIT,
		CFG_ACK
	} cfg_state_e;

endpackage

`default_nettype wire

/* src/gac_ingress_buffer.sv */
// ingress packet and metadata buffer

`default_nettype none

`include "gac_defines.svh"

module gac_ingress_buffer (
	input wire logic clk,
	input wire logic rst_n,
	input wire gac_pkg::pkt_word_t in_data,
	input wire logic in_data_wr,
	input wire logic in_eop_wr,
	input wire gac_pkg::md_t in_md,
	input wire logic in_md_wr,
	input wire logic data_pop,
	output gac_pkg::pkt_word_t data_head,
	input wire logic md_pop,
	output gac_pkg::md_t md_head,
	output logic md_empty,
	output logic pkt_avail,
	input wire logic pkt_done,
	output logic out_data_alf,
	output logic out_md_alf
);
	import gac_pkg::*;

	localparam int DW = $clog2(`GAC_DATA_DEPTH);
	localparam int MW = $clog2(`GAC_MD_DEPTH);
	localparam logic [DW:0] DATA_ALF_LVL = (DW + 1)'(`GAC_DATA_DEPTH - `GAC_ALF_MARGIN);
	localparam logic [MW:0] MD_ALF_LVL = (MW + 1)'(`GAC_MD_DEPTH - `GAC_ALF_MARGIN);

	pkt_word_t data_mem [`GAC_DATA_DEPTH];
	md_t md_mem [`GAC_MD_DEPTH];
	logic [DW-1:0] data_wp;
	logic [DW-1:0] data_rp;
	logic [DW:0] data_cnt;
	logic [MW-1:0] md_wp;
	logic [MW-1:0] md_rp;
	logic [MW:0] md_cnt;
	logic [DW:0] pkt_cnt; // complete packets waiting
	logic data_empty;
	logic data_full;
	logic md_full;

	// ********************
	// show-ahead heads and levels
	// ********************

	assign data_head = data_mem[data_rp];
	assign md_head = md_mem[md_rp];
	assign data_empty = (data_cnt == '0);
	assign data_full = (data_cnt == (DW + 1)'(`GAC_DATA_DEPTH));
	assign md_empty = (md_cnt == '0);
	assign md_full = (md_cnt == (MW + 1)'(`GAC_MD_DEPTH));
	assign out_data_alf = (data_cnt >= DATA_ALF_LVL);
	assign out_md_alf = (md_cnt >= MD_ALF_LVL);
	assign pkt_avail = (pkt_cnt != '0);

	always_ff @(posedge clk) begin
		if (in_data_wr)
			data_mem[data_wp] <= in_data;
		if (in_md_wr)
			md_mem[md_wp] <= in_md;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			data_wp <= '0;
			data_rp <= '0;
			data_cnt <= '0;
			md_wp <= '0;
			md_rp <= '0;
			md_cnt <= '0;
			pkt_cnt <= '0;
		end else begin
			data_wp <= data_wp + DW'(in_data_wr); // depths are powers of two
			data_rp <= data_rp + DW'(data_pop);
			data_cnt <= data_cnt + (DW + 1)'(in_data_wr) - (DW + 1)'(data_pop);
			md_wp <= md_wp + MW'(in_md_wr);
			md_rp <= md_rp + MW'(md_pop);
			md_cnt <= md_cnt + (MW + 1)'(in_md_wr) - (MW + 1)'(md_pop);
			pkt_cnt <= pkt_cnt + (DW + 1)'(in_eop_wr) - (DW + 1)'(pkt_done);
		end
	end

	// source must respect the almost-full levels
	a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
		!(in_data_wr && data_full) && !(in_md_wr && md_full));

	a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
		!(data_pop && data_empty) && !(md_pop && md_empty) && !(pkt_done && !pkt_avail));

endmodule

`default_nettype wire

/* src/gac_action_table.sv */
// action table with local-bus access

`default_nettype none

module gac_action_table (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic cfg_cs,
	input wire logic cfg_rw, // 0 write, 1 read
	input wire logic [15:0] cfg_addr,
	input wire gac_pkg::action_t cfg_wdata,
	output logic cfg_ack,
	output gac_pkg::action_t cfg_rdata,
	input wire gac_pkg::tbl_addr_t lookup_addr,
	output gac_pkg::action_t lookup_data
);
	import gac_pkg::*;

	action_t mem [256];
	cfg_state_e cfg_state;
	tbl_addr_t cfg_addr_q;
	action_t cfg_wdata_q;
	action_t cfg_rd_q; // bus port first read stage
	action_t lookup_q; // lookup port first read stage

	// ********************
	// bus sequencer
	// ********************

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cfg_state <= CFG_IDLE;
			cfg_ack <= 1'b0;
		end else begin
			cfg_ack <= 1'b0;
			case (cfg_state)
				CFG_IDLE: begin
					if (cfg_cs)
						cfg_state <= cfg_rw ? CFG_READ : CFG_WRITE;
				end
				CFG_WRITE: begin
					cfg_ack <= 1'b1; // ack 2 cycles after cs
					cfg_state <= CFG_ACK;
				end
				CFG_READ: cfg_state <= CFG_WAIT;
				CFG_WAIT: begin
					cfg_ack <= 1'b1; // rdata lands with this ack
					cfg_state <= CFG_ACK;
				end
				default: cfg_state <= CFG_IDLE; // cs ignored while acking
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (cfg_state == CFG_IDLE && cfg_cs) begin
			cfg_addr_q <= cfg_addr[9:2]; // word address
			cfg_wdata_q <= cfg_wdata;
		end
	end

	// ********************
	// dual-port memory
	// ********************

	always_ff @(posedge clk) begin
		if (cfg_state == CFG_WRITE)
			mem[cfg_addr_q] <= cfg_wdata_q;
		cfg_rd_q <= mem[cfg_addr_q];
		cfg_rdata <= cfg_rd_q;
		lookup_q <= mem[lookup_addr];
		lookup_data <= lookup_q;
	end

endmodule

`default_nettype wire

/* src/gac_decode.sv */
// packet start and table lookup

`default_nettype none

`include "gac_defines.svh"

module gac_decode (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic pkt_avail,
	input wire logic md_empty,
	input wire gac_pkg::md_t md_head,
	input wire logic out_alf,
	input wire logic result_busy,
	output logic md_pop,
	output gac_pkg::tbl_addr_t lookup_addr,
	input wire gac_pkg::action_t lookup_data,
	output gac_pkg::dec_item_t dec,
	output logic dec_valid
);
	import gac_pkg::*;

	dec_state_e state;
	md_t md_q;
	logic hit_q;
	logic start;
	logic local_hit;

	// out_alf only matters here, a started packet runs to its tail
	assign start = (state == DEC_IDLE) && pkt_avail && !md_empty && !out_alf && !result_busy;
	assign local_hit = (md_head.dmid == mid_t'(`GAC_LOCAL_MID));
	assign md_pop = start;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= DEC_IDLE;
			dec_valid <= 1'b0;
		end else begin
			dec_valid <= (state == DEC_ISSUE);
			case (state)
				DEC_IDLE: begin
					if (start)
						state <= local_hit ? DEC_LOOKUP : DEC_ISSUE;
				end
				DEC_LOOKUP: state <= DEC_WAIT; // table read stage 1
				DEC_WAIT: state <= DEC_ISSUE; // table read stage 2
				DEC_ISSUE: state <= DEC_BUSY;
				default: begin
					// hold until the result stage has taken the packet
					if (result_busy)
						state <= DEC_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			md_q <= md_head;
			hit_q <= local_hit;
			lookup_addr <= md_head.index;
		end
		if (state == DEC_ISSUE) begin
			dec.md <= md_q;
			dec.action <= hit_q ? lookup_data : '0;
			dec.hit <= hit_q;
		end
	end

endmodule

`default_nettype wire

/* src/gac_execute.sv */
// action execution on metadata

`default_nettype none

`include "gac_defines.svh"

module gac_execute (
	input wire logic clk,
	input wire logic rst_n,
	input wire gac_pkg::dec_item_t dec,
	input wire logic dec_valid,
	input wire gac_pkg::port_t max_cpuid,
	output gac_pkg::hdr_item_t hdr,
	output logic hdr_valid
);
	import gac_pkg::*;

	act_code_e code;
	md_t md_new;
	port_t poll_id; // next cpu thread for polling
	port_t poll_inc;
	logic poll_step;

	assign code = act_code_e'(dec.action[31:28]);
	assign poll_inc = poll_id + 6'd1;
	assign poll_step = dec_valid && dec.hit && (code == ACT_CPU_POLL);

	always_comb begin
		md_new = dec.md;
		md_new.dmid = mid_t'(`GAC_NEXT_MID);
		case (code)
			ACT_CPU_FIXED: begin
				md_new.pkt_des = 1'b1;
				md_new.out_type = 2'd1;
				md_new.out_port = dec.action[5:0];
			end
			ACT_CPU_POLL: begin
				md_new.pkt_des = 1'b1;
				md_new.out_type = 2'd2;
				md_new.out_port = poll_id;
			end
			ACT_PORT: begin
				md_new.pkt_des = 1'b0;
				md_new.out_type = 2'd0;
				md_new.out_port = dec.action[5:0];
			end
			ACT_SET_MID: begin
				md_new.pkt_des = 1'b1;
				md_new.out_type = 2'd0;
				md_new.dmid = dec.action[7:0]; // out_port kept
			end
			default: ; // plain forward
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hdr_valid <= 1'b0;
			poll_id <= '0;
		end else begin
			hdr_valid <= dec_valid;
			if (poll_step)
				poll_id <= (poll_inc < max_cpuid) ? poll_inc : '0;
		end
	end

	always_ff @(posedge clk) begin
		if (dec_valid) begin
			hdr.md <= dec.hit ? md_new : dec.md;
			hdr.keep_first <= !dec.hit;
		end
	end

endmodule

`default_nettype wire

/* src/gac_result.sv */
// packet output with rewritten header

`default_nettype none

module gac_result (
	input wire logic clk,
	input wire logic rst_n,
	input wire gac_pkg::hdr_item_t hdr,
	input wire logic hdr_valid,
	input wire gac_pkg::pkt_word_t data_head,
	output logic data_pop,
	output logic pkt_done,
	output logic result_busy,
	output gac_pkg::pkt_word_t out_data,
	output logic out_data_wr,
	output logic out_valid
);
	import gac_pkg::*;

	marker_t head_mark;
	logic busy_q; // body words still to copy
	logic moving;
	logic is_tail;

	assign head_mark = data_head[133:132];
	assign is_tail = (head_mark == MARK_TAIL);
	assign moving = hdr_valid || busy_q;
	assign data_pop = moving; // one word per cycle, never paused
	assign result_busy = moving;
	assign pkt_done = moving && is_tail;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy_q <= 1'b0;
			out_data_wr <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			out_data_wr <= moving;
			out_valid <= pkt_done; // rides with the tail word
			if (pkt_done)
				busy_q <= 1'b0;
			else if (hdr_valid)
				busy_q <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (moving) begin
			// top six bits hold marker and byte info, rest is metadata
			if (hdr_valid && !hdr.keep_first)
				out_data <= {data_head[133:128], hdr.md};
			else
				out_data <= data_head;
		end
	end

	// decode must not issue a header while a packet streams
	a_one_in_flight: assert property (@(posedge clk) disable iff (!rst_n)
		hdr_valid |-> !busy_q);

endmodule

`default_nettype wire

/* src/gac.sv */
// group action classifier top

`default_nettype none

module gac (
	input wire logic clk,
	input wire logic rst_n,
	input wire gac_pkg::pkt_word_t in_data,
	input wire logic in_data_wr,
	input wire logic in_eop_wr,
	input wire gac_pkg::md_t in_md,
	input wire logic in_md_wr,
	output logic out_data_alf,
	output logic out_md_alf,
	input wire gac_pkg::port_t max_cpuid,
	output gac_pkg::pkt_word_t out_data,
	output logic out_data_wr,
	output logic out_valid,
	input wire logic out_alf,
	input wire logic cfg_cs,
	input wire logic cfg_rw,
	input wire logic [15:0] cfg_addr,
	input wire gac_pkg::action_t cfg_wdata,
	output logic cfg_ack,
	output gac_pkg::action_t cfg_rdata
);
	import gac_pkg::*;

	pkt_word_t data_head;
	md_t md_head;
	logic data_pop;
	logic md_pop;
	logic md_empty;
	logic pkt_avail;
	logic pkt_done;
	tbl_addr_t lookup_addr;
	action_t lookup_data;
	dec_item_t dec;
	logic dec_valid;
	hdr_item_t hdr;
	logic hdr_valid;
	logic result_busy;

	// ********************
	// stages
	// ********************

	gac_ingress_buffer u_ingress (
		.clk(clk), .rst_n(rst_n),
		.in_data(in_data), .in_data_wr(in_data_wr), .in_eop_wr(in_eop_wr),
		.in_md(in_md), .in_md_wr(in_md_wr),
		.data_pop(data_pop), .data_head(data_head),
		.md_pop(md_pop), .md_head(md_head), .md_empty(md_empty),
		.pkt_avail(pkt_avail), .pkt_done(pkt_done),
		.out_data_alf(out_data_alf), .out_md_alf(out_md_alf)
	);

	gac_action_table u_table (
		.clk(clk), .rst_n(rst_n),
		.cfg_cs(cfg_cs), .cfg_rw(cfg_rw), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
		.cfg_ack(cfg_ack), .cfg_rdata(cfg_rdata),
		.lookup_addr(lookup_addr), .lookup_data(lookup_data)
	);

	gac_decode u_decode (
		.clk(clk), .rst_n(rst_n),
		.pkt_avail(pkt_avail), .md_empty(md_empty), .md_head(md_head),
		.out_alf(out_alf), .result_busy(result_busy), .md_pop(md_pop),
		.lookup_addr(lookup_addr), .lookup_data(lookup_data),
		.dec(dec), .dec_valid(dec_valid)
	);

	gac_execute u_execute (
		.clk(clk), .rst_n(rst_n),
		.dec(dec), .dec_valid(dec_valid), .max_cpuid(max_cpuid),
		.hdr(hdr), .hdr_valid(hdr_valid)
	);

	gac_result u_result (
		.clk(clk), .rst_n(rst_n),
		.hdr(hdr), .hdr_valid(hdr_valid),
		.data_head(data_head), .data_pop(data_pop),
		.pkt_done(pkt_done), .result_busy(result_busy),
		.out_data(out_data), .out_data_wr(out_data_wr), .out_valid(out_valid)
	);

endmodule

`default_nettype wire

/* sim/gac_tb.sv */
// group action classifier testbench

`default_nettype none

`include "gac_defines.svh"

module gac_tb;
	import gac_pkg::*;

	localparam int DATA_ALF_LVL = `GAC_DATA_DEPTH - `GAC_ALF_MARGIN;
	localparam int MD_ALF_LVL = `GAC_MD_DEPTH - `GAC_ALF_MARGIN;

	logic clk;
	logic rst_n;
	pkt_word_t in_data;
	logic in_data_wr;
	logic in_eop_wr;
	md_t in_md;
	logic in_md_wr;
	logic out_data_alf;
	logic out_md_alf;
	port_t max_cpuid;
	pkt_word_t out_data;
	logic out_data_wr;
	logic out_valid;
	logic out_alf;
	logic cfg_cs;
	logic cfg_rw;
	logic [15:0] cfg_addr;
	action_t cfg_wdata;
	logic cfg_ack;
	action_t cfg_rdata;

	int fd;
	int checks;
	int errors;
	int mon_errors; // raised by the output monitor only
	int sent_pkts;
	int out_pkts;
	int data_words; // packet words written into the DUT
	logic [8*16-1:0] tname;
	logic in_test;
	int checks0;
	int errors0;

	// packet being sent and its expected output
	pkt_word_t pkt_w [16];
	int pkt_n;
	md_t pkt_md;
	logic pkt_alf;
	pkt_word_t exp_q [$];
	logic exp_tail_q [$];

	// output words in arrival order
	pkt_word_t got_word [1024];
	logic got_tail [1024];
	time got_time [1024];
	int got_cnt;
	int got_rd;

	gac gac_inst (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ********************
	// output monitor
	// ********************

	always @(negedge clk) begin
		if (rst_n) begin
			if (out_data_wr && got_cnt < 1024) begin
				got_word[got_cnt] = out_data;
				got_tail[got_cnt] = out_valid;
				got_time[got_cnt] = $time;
				got_cnt++;
			end else if (out_data_wr) begin
				mon_errors++;
				$display("more output words than the monitor can hold");
			end
			if (out_valid && !out_data_wr) begin
				mon_errors++;
				$display("out_valid pulsed at %0t without an output word", $time);
			end
			if (out_data_wr && out_alf) begin
				mon_errors++;
				$display("output word written at %0t while out_alf was high", $time);
			end
			// buffered counts here are upper bounds of the real fill levels
			if (out_data_alf && data_words - got_cnt < DATA_ALF_LVL) begin
				mon_errors++;
				$display("[ERROR] t=%0t out_data_alf expected 0 got %0b", $time, out_data_alf);
			end
			if (out_md_alf && sent_pkts - out_pkts < MD_ALF_LVL) begin
				mon_errors++;
				$display("[ERROR] t=%0t out_md_alf expected 0 got %0b", $time, out_md_alf);
			end
			if (out_valid)
				out_pkts++;
		end
	end

	initial begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles < sent_pkts * 64 + 200) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles, outputs stopped arriving", cycles);
		$display("CHECKS FAILED");
		$finish;
	end

	// ********************
	// expected values
	// ********************

	function automatic md_t rewrite_md(md_t md, logic des, logic [1:0] otype,
			port_t oport, mid_t dmid);
		md_t m;
		m = md;
		m.pkt_des = des;
		m.out_type = otype;
		m.out_port = oport;
		m.dmid = dmid;
		return m;
	endfunction

	task expect_packet;
		int rc;
		logic keep;
		logic des;
		logic [1:0] otype;
		port_t oport;
		mid_t dmid;
		rc = $fscanf(fd, "%h %h %h %h %h", keep, des, otype, oport, dmid);
		if (keep)
			exp_q.push_back(pkt_w[0]);
		else
			exp_q.push_back({pkt_w[0][133:128], rewrite_md(pkt_md, des, otype, oport, dmid)});
		exp_tail_q.push_back(pkt_n == 1);
		for (int i = 1; i < pkt_n; i++) begin
			exp_q.push_back(pkt_w[i]); // body words unchanged
			exp_tail_q.push_back(i == pkt_n - 1);
		end
	endtask

	// ********************
	// drivers
	// ********************

	task bus_access(input logic rw, input logic [15:0] addr, input action_t wdata,
			input action_t exp_data);
		int lat;
		logic got;
		@(posedge clk);
		#2;
		cfg_cs = 1'b1;
		cfg_rw = rw;
		cfg_addr = addr;
		cfg_wdata = wdata;
		lat = 0;
		got = 1'b0;
		while (!got && lat < 8) begin
			@(posedge clk);
			#2;
			cfg_cs = 1'b0; // one-cycle strobe
			lat++;
			@(negedge clk);
			got = cfg_ack;
		end
		checks++;
		if (!got) begin
			errors++;
			$display("no cfg_ack within 8 cycles for address %h", addr);
		end else if (lat != (rw ? 3 : 2)) begin
			errors++;
			$display("[ERROR] t=%0t cfg_ack latency expected %0d got %0d",
				$time, rw ? 3 : 2, lat);
		end
		if (rw && got) begin
			checks++;
			if (cfg_rdata !== exp_data) begin
				errors++;
				$display("[ERROR] t=%0t cfg_rdata expected %h got %h", $time, exp_data, cfg_rdata);
			end
		end
	endtask

	task read_packet;
		int rc;
		int alf;
		logic [127:0] md_raw;
		logic [7:0] dtag;
		marker_t mk;
		logic [131:0] lo;
		rc = $fscanf(fd, "%d %h %d", pkt_n, md_raw, alf);
		pkt_md = md_raw;
		pkt_alf = (alf != 0);
		for (int i = 0; i < pkt_n; i++) begin
			rc = $fscanf(fd, " %c %h %h", dtag, mk, lo);
			pkt_w[i] = {mk, lo};
		end
	endtask

	task send_packet;
		if (pkt_alf && !out_alf)
			wait (out_pkts == sent_pkts); // drain before holding downstream
		@(posedge clk);
		#2;
		out_alf = pkt_alf;
		for (int i = 0; i < pkt_n; i++) begin
			in_data = pkt_w[i];
			in_data_wr = 1'b1;
			@(posedge clk);
			#2;
			data_words++;
		end
		in_data_wr = 1'b0;
		in_eop_wr = 1'b1; // after the tail word
		in_md = pkt_md;
		in_md_wr = 1'b1;
		@(posedge clk);
		#2;
		in_eop_wr = 1'b0;
		in_md_wr = 1'b0;
		sent_pkts++;
	endtask

	task close_test;
		pkt_word_t exp_w;
		logic exp_t;
		if (in_test) begin
			wait (out_pkts == sent_pkts);
			while (exp_q.size() > 0) begin
				exp_w = exp_q.pop_front();
				exp_t = exp_tail_q.pop_front();
				checks++;
				if (got_rd >= got_cnt) begin
					errors++;
					$display("missing output word, expected %h", exp_w);
				end else begin
					if (got_word[got_rd] !== exp_w) begin
						errors++;
						$display("[ERROR] t=%0t out_data expected %h got %h",
							got_time[got_rd], exp_w, got_word[got_rd]);
					end
					if (got_tail[got_rd] !== exp_t) begin
						errors++;
						$display("[ERROR] t=%0t out_valid expected %0b got %0b",
							got_time[got_rd], exp_t, got_tail[got_rd]);
					end
					got_rd++;
				end
			end
			if (got_rd < got_cnt) begin
				errors++;
				$display("%0d output words that no packet expected", got_cnt - got_rd);
				got_rd = got_cnt;
			end
			$display("test %0s: %0d checks, %0d errors", tname, checks - checks0,
				errors + mon_errors - errors0);
		end
	endtask

	// ********************
	// main sequence
	// ********************

	initial begin : stimulus
		logic [7:0] tag;
		logic [8*128-1:0] line;
		int rc;
		logic done;
		logic [15:0] addr;
		action_t data;
		port_t cpu;
		rst_n = 1'b0;
		in_data = '0;
		in_data_wr = 1'b0;
		in_eop_wr = 1'b0;
		in_md = '0;
		in_md_wr = 1'b0;
		max_cpuid = '0;
		out_alf = 1'b0;
		cfg_cs = 1'b0;
		cfg_rw = 1'b0;
		cfg_addr = '0;
		cfg_wdata = '0;
		checks = 0;
		errors = 0;
		mon_errors = 0;
		sent_pkts = 0;
		out_pkts = 0;
		data_words = 0;
		got_cnt = 0;
		got_rd = 0;
		in_test = 1'b0;
		repeat (8) @(posedge clk);
		#2;
		rst_n = 1'b1;
		fd = $fopen("sim/gac_testdata.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("cannot open sim/gac_testdata.txt");
		end else begin
			done = 1'b0;
			while (!done) begin
				rc = $fscanf(fd, " %c", tag);
				if (rc != 1) begin
					done = 1'b1;
				end else begin
					case (tag)
						"#": rc = $fgets(line, fd); // comment line
						"T": begin
							close_test();
							rc = $fscanf(fd, "%s", tname);
							checks0 = checks;
							errors0 = errors + mon_errors;
							in_test = 1'b1;
						end
						"W": begin
							rc = $fscanf(fd, "%h %h", addr, data);
							bus_access(1'b0, addr, data, '0);
						end
						"R": begin
							rc = $fscanf(fd, "%h %h", addr, data);
							bus_access(1'b1, addr, '0, data);
						end
						"M": begin
							rc = $fscanf(fd, "%h", cpu);
							@(posedge clk);
							#2;
							max_cpuid = cpu;
						end
						"P": begin
							read_packet();
							send_packet();
						end
						"E": expect_packet();
						default: begin
							errors++;
							$display("unknown record tag %c in the data file", tag);
							done = 1'b1;
						end
					endcase
				end
			end
			close_test();
			$fclose(fd);
		end
		$display("total: %0d checks, %0d errors", checks, errors + mon_errors);
		if (errors + mon_errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* sim/gac_testdata.txt */
# T name | W addr entry | R addr expected | M max_cpuid | P words md out_alf (hex md)
# D marker word for each packet word | E keep pkt_des out_type out_port dmid
T table
W 0010 10000011
R 0010 10000011
W 0020 30000007
R 0020 30000007
W 0030 40000033
R 0030 40000033
W 0040 20000000
R 0040 20000000
W 0050 000000ab
R 0050 000000ab
T foreign
P 3 85EAB12345076789A813BCDEF0123456 0
D 1 a0123456789abcdef0123456789abcdef
D 3 5555aaaa0000ffff
D 2 1234
E 1 0 0 00 00
T rewrite
P 2 85EAB12345046789A813BCDEF0123456 0
D 1 b0123456789abcdef0123456789abcdef
D 2 c0ffee01
E 0 1 1 11 05
P 2 85EAB12345046789A823BCDEF0123456 0
D 1 cfedcba9876543210fedcba9876543210
D 2 c0ffee02
E 0 0 0 07 05
P 2 85EAB12345046789A833BCDEF0123456 0
D 1 d0123456789abcdef0123456789abcdef
D 2 c0ffee03
E 0 1 0 2a 33
T polling
M 03
P 1 85EAB12345046789A843BCDEF0123456 0
D 2 ab01
E 0 1 2 00 05
P 1 85EAB12345046789A843BCDEF0123456 0
D 2 ab02
E 0 1 2 01 05
P 1 85EAB12345046789A843BCDEF0123456 0
D 2 ab03
E 0 1 2 02 05
P 1 85EAB12345046789A843BCDEF0123456 0
D 2 ab04
E 0 1 2 00 05
P 1 85EAB12345046789A843BCDEF0123456 0
D 2 ab05
E 0 1 2 01 05
T forward
P 2 85EAB12345046789A853BCDEF0123456 0
D 1 f0123456789abcdef0123456789abcdef
D 2 77
E 0 0 3 2a 05
T backpress
P 2 85EAB12345046789A823BCDEF0123456 1
D 1 9fedcba9876543210fedcba9876543210
D 2 beef01
E 0 0 0 07 05
P 1 85EAB12345076789A813BCDEF0123456 1
D 2 beef02
E 1 0 0 00 00
P 2 85EAB12345046789A813BCDEF0123456 0
D 1 80123456789abcdef0123456789abcdef
D 2 beef03
E 0 1 1 11 05

/* gac.f */
+incdir+include
src/gac_pkg.sv
src/gac_ingress_buffer.sv
src/gac_action_table.sv
src/gac_decode.sv
src/gac_execute.sv
src/gac_result.sv
src/gac.sv
sim/gac_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f gac.f --top-module gac_tb -o gac_sim
./obj_dir/gac_sim | tee sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
